// ==== common/reassembly_pkg.sv ====
package reassembly_pkg;

    //////////////////////////////////////////////////////////////////////
    // Sizes
    //////////////////////////////////////////////////////////////////////

    // Fragment slots working in parallel
    localparam int num_slots = 4;

    // Bytes per slot FIFO, also the longest packet accepted
    localparam int slot_depth = 2048;

    // Wide enough to hold slot_depth
    localparam int length_width = 12;

    //////////////////////////////////////////////////////////////////////
    // Types
    //////////////////////////////////////////////////////////////////////

    typedef logic [1:0] slot_index_t;

    // IPv4 identification field
    typedef logic [15:0] packet_id_t;

    typedef enum logic [1:0] {
        slot_idle,
        slot_capture,
        slot_drain
    } slot_state_t;

endpackage

// ==== common/fragment_stream_if.sv ====
`timescale 1ns/1ps

// One byte per cycle from the dispatcher into a single slot
interface fragment_stream_if;

    logic [7:0] data;
    logic       valid;
    logic       fragment_last;
    // Held for every byte of the packet's final fragment
    logic       final_fragment;

    modport source (
        output data,
        output valid,
        output fragment_last,
        output final_fragment
    );

    modport sink (
        input data,
        input valid,
        input fragment_last,
        input final_fragment
    );

endinterface

// ==== logic/sync_fifo.sv ====
`timescale 1ns/1ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  depth     = 16
) (
    input  logic     clock,
    input  logic     reset_n,
    input  logic     write_enable,
    input  payload_t write_data,
    input  logic     read_enable,
    output payload_t read_data,
    output logic     read_data_valid,
    output logic     full,
    output logic     empty
);

    payload_t                   memory [depth];
    logic [$clog2(depth)-1:0]   write_pointer;
    logic [$clog2(depth)-1:0]   read_pointer;
    logic [$clog2(depth):0]     count;
    logic                       do_write;
    logic                       do_read;

    assign full     = (count == depth);
    assign empty    = (count == 0);

    // Writes into a full buffer and reads from an empty one are dropped
    assign do_write = write_enable && !full;
    assign do_read  = read_enable && !empty;

    always_ff @(posedge clock) begin
        if (do_write) begin
            memory[write_pointer] <= write_data;
        end
        if (do_read) begin
            read_data <= memory[read_pointer];
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_pointer   <= '0;
            read_pointer    <= '0;
            count           <= '0;
            read_data_valid <= 1'b0;
        end else begin
            if (do_write) begin
                write_pointer <= write_pointer + 1'b1;
            end
            if (do_read) begin
                read_pointer <= read_pointer + 1'b1;
            end
            // Strobe lines up with the registered read data
            read_data_valid <= do_read;
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== fragment_slot/fragment_slot.sv ====
`timescale 1ns/1ps

module fragment_slot (
    input  logic                        clock,
    input  logic                        reset_n,
    fragment_stream_if.sink             bytes_in,
    input  logic                        drain_read,
    output reassembly_pkg::slot_state_t state,
    output reassembly_pkg::packet_id_t  current_packet_id,
    input  reassembly_pkg::packet_id_t  new_packet_id,
    output logic                        complete,
    output logic [7:0]                  byte_data,
    output logic                        byte_valid,
    output logic                        byte_last
);

    logic [7:0]                             buffer_data;
    logic                                   buffer_valid;
    logic                                   buffer_end;
    logic [reassembly_pkg::length_width-1:0] byte_count;
    logic                                   last_read;
    logic                                   fifo_read;
    logic                                   fifo_empty;
    logic                                   fifo_full;
    logic                                   fifo_read_data_valid;

    //////////////////////////////////////////////////////////////////////
    // Packet storage
    //////////////////////////////////////////////////////////////////////

    sync_fifo #(
        .payload_t (logic [7:0]),
        .depth     (reassembly_pkg::slot_depth)
    ) byte_fifo (
        .clock           (clock),
        .reset_n         (reset_n),
        .write_enable    (buffer_valid && !fifo_full),
        .write_data      (buffer_data),
        .read_enable     (fifo_read),
        .read_data       (byte_data),
        .read_data_valid (fifo_read_data_valid),
        .full            (fifo_full),
        .empty           (fifo_empty)
    );

    // Reads only count while there is something to read
    assign fifo_read  = drain_read && (state == reassembly_pkg::slot_drain) && !fifo_empty;

    // Final byte of the final fragment goes into the FIFO this cycle
    assign complete   = buffer_valid && buffer_end;

    assign byte_valid = fifo_read_data_valid;
    assign byte_last  = fifo_read_data_valid && last_read;

    // One byte input register, payload only
    always_ff @(posedge clock) begin
        buffer_data <= bytes_in.data;
        buffer_end  <= bytes_in.fragment_last && bytes_in.final_fragment;
    end

    //////////////////////////////////////////////////////////////////////
    // Slot FSM and byte counter
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state             <= reassembly_pkg::slot_idle;
            current_packet_id <= '0;
            buffer_valid      <= 1'b0;
            byte_count        <= '0;
            last_read         <= 1'b0;
        end else begin
            buffer_valid <= bytes_in.valid && (state != reassembly_pkg::slot_drain);
            last_read    <= fifo_read && (byte_count == 1);

            case (state)
                reassembly_pkg::slot_idle: begin
                    if (bytes_in.valid) begin
                        state             <= reassembly_pkg::slot_capture;
                        current_packet_id <= new_packet_id;
                    end
                end
                reassembly_pkg::slot_capture: begin
                    if (complete) begin
                        state <= reassembly_pkg::slot_drain;
                    end
                end
                reassembly_pkg::slot_drain: begin
                    // Empty only after the last byte has been read out
                    if (fifo_empty) begin
                        state <= reassembly_pkg::slot_idle;
                    end
                end
                default: begin
                    state <= reassembly_pkg::slot_idle;
                end
            endcase

            // Up while storing, down while draining
            if (buffer_valid && !fifo_full) begin
                byte_count <= byte_count + 1'b1;
            end else if (fifo_read) begin
                byte_count <= byte_count - 1'b1;
            end
        end
    end

endmodule

// ==== fragment_slot/slot_dispatcher.sv ====
`timescale 1ns/1ps

module slot_dispatcher (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic [7:0]                  in_data,
    input  logic                        in_valid,
    input  logic                        in_fragment_last,
    input  logic                        in_final,
    input  reassembly_pkg::packet_id_t  in_packet_id,
    input  reassembly_pkg::slot_state_t slot_state [reassembly_pkg::num_slots],
    input  reassembly_pkg::packet_id_t  slot_packet_id [reassembly_pkg::num_slots],
    fragment_stream_if.source           slot_bytes [reassembly_pkg::num_slots],
    output reassembly_pkg::packet_id_t  slot_packet_id_out,
    output logic                        drop
);

    logic                                   in_fragment;
    logic                                   fragment_start;
    logic                                   held_discard;
    reassembly_pkg::slot_index_t            held_index;
    logic [reassembly_pkg::num_slots-1:0]   booked;
    logic [reassembly_pkg::num_slots-1:0]   slot_match;
    logic [reassembly_pkg::num_slots-1:0]   slot_free;
    logic                                   match_found;
    logic                                   free_found;
    reassembly_pkg::slot_index_t            match_index;
    reassembly_pkg::slot_index_t            free_index;
    reassembly_pkg::slot_index_t            target_index;
    logic                                   discard;
    logic [reassembly_pkg::num_slots-1:0]   valid_q;
    logic [7:0]                             data_q;
    logic                                   fragment_last_q;
    logic                                   final_q;

    assign fragment_start = in_valid && !in_fragment;

    //////////////////////////////////////////////////////////////////////
    // Slot lookup at fragment start
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        match_found = 1'b0;
        free_found  = 1'b0;
        match_index = '0;
        free_index  = '0;
        // Walk downwards so the lowest slot wins
        for (int i = reassembly_pkg::num_slots - 1; i >= 0; i--) begin
            // A booked slot still looks idle but already owns the last id sent
            slot_match[i] = ((slot_state[i] == reassembly_pkg::slot_capture) &&
                             (slot_packet_id[i] == in_packet_id)) ||
                            (booked[i] && (slot_state[i] == reassembly_pkg::slot_idle) &&
                             (slot_packet_id_out == in_packet_id));
            slot_free[i]  = (slot_state[i] == reassembly_pkg::slot_idle) && !booked[i];
            if (slot_match[i]) begin
                match_found = 1'b1;
                match_index = reassembly_pkg::slot_index_t'(i);
            end
            if (slot_free[i]) begin
                free_found = 1'b1;
                free_index = reassembly_pkg::slot_index_t'(i);
            end
        end
    end

    assign target_index = !fragment_start ? held_index :
                          (match_found ? match_index : free_index);
    assign discard      = fragment_start ? !(match_found || free_found) : held_discard;

    //////////////////////////////////////////////////////////////////////
    // Byte forwarding
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (in_valid) begin
            data_q             <= in_data;
            fragment_last_q    <= in_fragment_last;
            final_q            <= in_final;
            slot_packet_id_out <= in_packet_id;
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            in_fragment  <= 1'b0;
            held_discard <= 1'b0;
            held_index   <= '0;
            booked       <= '0;
            valid_q      <= '0;
            drop         <= 1'b0;
        end else begin
            if (in_valid) begin
                in_fragment <= !in_fragment_last;
            end
            if (fragment_start) begin
                held_index   <= target_index;
                held_discard <= discard;
            end
            drop <= fragment_start && discard;
            for (int i = 0; i < reassembly_pkg::num_slots; i++) begin
                valid_q[i] <= in_valid && !discard && (target_index == i);
                // Booking lasts until the slot leaves idle
                if (slot_state[i] != reassembly_pkg::slot_idle) begin
                    booked[i] <= 1'b0;
                end else if (fragment_start && !match_found && free_found &&
                             (free_index == i)) begin
                    booked[i] <= 1'b1;
                end
            end
        end
    end

    for (genvar i = 0; i < reassembly_pkg::num_slots; i++) begin : g_slot_bytes
        assign slot_bytes[i].data           = data_q;
        assign slot_bytes[i].valid          = valid_q[i];
        assign slot_bytes[i].fragment_last  = fragment_last_q;
        assign slot_bytes[i].final_fragment = final_q;
    end

endmodule

// ==== logic/drain_arbiter.sv ====
`timescale 1ns/1ps

module drain_arbiter (
    input  logic                                clock,
    input  logic                                reset_n,
    input  logic [reassembly_pkg::num_slots-1:0] complete,
    input  logic [7:0]                          slot_byte_data [reassembly_pkg::num_slots],
    input  logic [reassembly_pkg::num_slots-1:0] slot_byte_valid,
    input  logic [reassembly_pkg::num_slots-1:0] slot_byte_last,
    input  reassembly_pkg::packet_id_t          slot_packet_id [reassembly_pkg::num_slots],
    output logic [reassembly_pkg::num_slots-1:0] drain_read,
    input  logic                                out_ready,
    output logic [7:0]                          out_data,
    output logic                                out_valid,
    output logic                                out_last,
    output reassembly_pkg::packet_id_t          out_packet_id
);

    reassembly_pkg::slot_index_t    complete_index;
    reassembly_pkg::slot_index_t    queue_data;
    logic                           queue_data_valid;
    logic                           queue_empty;
    logic                           queue_pop;
    logic                           busy;
    logic                           selected;
    reassembly_pkg::slot_index_t    active;

    // At most one slot completes per cycle
    always_comb begin
        complete_index = '0;
        for (int i = 0; i < reassembly_pkg::num_slots; i++) begin
            if (complete[i]) begin
                complete_index = reassembly_pkg::slot_index_t'(i);
            end
        end
    end

    // Completed slots in order of completion
    sync_fifo #(
        .payload_t (reassembly_pkg::slot_index_t),
        .depth     (reassembly_pkg::num_slots)
    ) completion_fifo (
        .clock           (clock),
        .reset_n         (reset_n),
        .write_enable    (|complete),
        .write_data      (complete_index),
        .read_enable     (queue_pop),
        .read_data       (queue_data),
        .read_data_valid (queue_data_valid),
        .full            (),
        .empty           (queue_empty)
    );

    // Next slot only once the previous packet has fully left
    assign queue_pop = !busy && !queue_empty;

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            busy     <= 1'b0;
            selected <= 1'b0;
            active   <= '0;
        end else begin
            if (queue_pop) begin
                busy <= 1'b1;
            end
            if (queue_data_valid) begin
                active   <= queue_data;
                selected <= 1'b1;
            end
            if (selected && slot_byte_last[active]) begin
                busy     <= 1'b0;
                selected <= 1'b0;
            end
        end
    end

    // Output mux from the active slot
    always_comb begin
        drain_read         = '0;
        drain_read[active] = selected && out_ready;
    end

    assign out_data      = slot_byte_data[active];
    assign out_valid     = selected && slot_byte_valid[active];
    assign out_last      = selected && slot_byte_last[active];
    assign out_packet_id = slot_packet_id[active];

endmodule

// ==== fragment_reassembly_top.sv ====
`timescale 1ns/1ps

module fragment_reassembly_top (
    input  logic                        clock,
    input  logic                        reset_n,
    input  logic [7:0]                  in_data,
    input  logic                        in_valid,
    input  logic                        in_fragment_last,
    input  logic                        in_final,
    input  reassembly_pkg::packet_id_t  in_packet_id,
    input  logic                        out_ready,
    output logic [7:0]                  out_data,
    output logic                        out_valid,
    output logic                        out_last,
    output reassembly_pkg::packet_id_t  out_packet_id,
    output logic                        drop
);

    reassembly_pkg::slot_state_t            slot_state [reassembly_pkg::num_slots];
    reassembly_pkg::packet_id_t             slot_packet_id [reassembly_pkg::num_slots];
    reassembly_pkg::packet_id_t             new_packet_id;
    logic [reassembly_pkg::num_slots-1:0]   complete;
    logic [reassembly_pkg::num_slots-1:0]   drain_read;
    logic [7:0]                             byte_data [reassembly_pkg::num_slots];
    logic [reassembly_pkg::num_slots-1:0]   byte_valid;
    logic [reassembly_pkg::num_slots-1:0]   byte_last;

    fragment_stream_if slot_bytes [reassembly_pkg::num_slots] ();

    slot_dispatcher dispatcher (
        .clock              (clock),
        .reset_n            (reset_n),
        .in_data            (in_data),
        .in_valid           (in_valid),
        .in_fragment_last   (in_fragment_last),
        .in_final           (in_final),
        .in_packet_id       (in_packet_id),
        .slot_state         (slot_state),
        .slot_packet_id     (slot_packet_id),
        .slot_bytes         (slot_bytes),
        .slot_packet_id_out (new_packet_id),
        .drop               (drop)
    );

    for (genvar i = 0; i < reassembly_pkg::num_slots; i++) begin : g_slot
        fragment_slot slot (
            .clock             (clock),
            .reset_n           (reset_n),
            .bytes_in          (slot_bytes[i]),
            .drain_read        (drain_read[i]),
            .state             (slot_state[i]),
            .current_packet_id (slot_packet_id[i]),
            .new_packet_id     (new_packet_id),
            .complete          (complete[i]),
            .byte_data         (byte_data[i]),
            .byte_valid        (byte_valid[i]),
            .byte_last         (byte_last[i])
        );
    end

    drain_arbiter arbiter (
        .clock           (clock),
        .reset_n         (reset_n),
        .complete        (complete),
        .slot_byte_data  (byte_data),
        .slot_byte_valid (byte_valid),
        .slot_byte_last  (byte_last),
        .slot_packet_id  (slot_packet_id),
        .drain_read      (drain_read),
        .out_ready       (out_ready),
        .out_data        (out_data),
        .out_valid       (out_valid),
        .out_last        (out_last),
        .out_packet_id   (out_packet_id)
    );

endmodule

// ==== sim/clock_gen.sv ====
`timescale 1ns/1ps

// Free running 4 ns clock and a reset held for the first 8 cycles
module clock_gen (
    output logic clock,
    output logic reset_n
);

    initial begin
        clock = 1'b0;
        forever begin
            #2 clock = ~clock;
        end
    end

    initial begin
        reset_n = 1'b0;
        repeat (8) @(posedge clock);
        // Release away from the active edge
        @(negedge clock);
        reset_n = 1'b1;
    end

endmodule

// ==== sim/reassembly_sva.sv ====
`timescale 1ns/1ps

module reassembly_sva (
    input logic                       clock,
    input logic                       reset_n,
    input logic                       out_valid,
    input logic                       out_last,
    input reassembly_pkg::packet_id_t out_packet_id,
    input logic                       drop
);

    logic                       packet_open;
    reassembly_pkg::packet_id_t packet_id_first;

    // Remembers the id seen on the first byte of the packet in flight
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            packet_open     <= 1'b0;
            packet_id_first <= '0;
        end else if (out_valid) begin
            packet_open <= !out_last;
            if (!packet_open) begin
                packet_id_first <= out_packet_id;
            end
        end
    end

    quiet_in_reset: assert property (@(posedge clock)
        !reset_n |-> !out_valid && !out_last && !drop)
        else $error("Output strobe or drop active during reset");

    last_with_valid: assert property (@(posedge clock) disable iff (!reset_n)
        out_last |-> out_valid)
        else $error("out_last high without out_valid");

    id_stable_in_packet: assert property (@(posedge clock) disable iff (!reset_n)
        out_valid && packet_open |-> out_packet_id == packet_id_first)
        else $error("out_packet_id changed inside a packet");

    single_cycle_drop: assert property (@(posedge clock) disable iff (!reset_n)
        drop |=> !drop)
        else $error("drop high on two cycles in a row");

endmodule

bind fragment_reassembly_top reassembly_sva sva0 (
    .clock         (clock),
    .reset_n       (reset_n),
    .out_valid     (out_valid),
    .out_last      (out_last),
    .out_packet_id (out_packet_id),
    .drop          (drop)
);

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps

module tb_top;

    localparam int num_packets   = 12;
    localparam int max_fragments = 3;
    localparam int max_length    = 128;

    logic                       clock;
    logic                       reset_n;
    logic [7:0]                 in_data;
    logic                       in_valid;
    logic                       in_fragment_last;
    logic                       in_final;
    reassembly_pkg::packet_id_t in_packet_id;
    logic                       out_ready;
    logic [7:0]                 out_data;
    logic                       out_valid;
    logic                       out_last;
    reassembly_pkg::packet_id_t out_packet_id;
    logic                       drop;

    // Test packets, each split into fragments
    logic [7:0]                 packet_store [num_packets][max_length];
    reassembly_pkg::packet_id_t packet_id [num_packets];
    int                         frag_len [num_packets][max_fragments];
    int                         frag_count [num_packets];
    int                         frag_index [num_packets];
    int                         sent_bytes [num_packets];

    // Scoreboard with one entry per output byte in completion order
    logic [7:0]                 expected_data [$];
    logic                       expected_last [$];
    reassembly_pkg::packet_id_t expected_id [$];

    int                         total_bytes;
    int                         drop_count;
    int                         cycle_count;
    int                         cycle_limit;
    logic                       ready_random;
    logic                       ready_level;

    clock_gen clocks (
        .clock   (clock),
        .reset_n (reset_n)
    );

    fragment_reassembly_top dut0 (
        .clock            (clock),
        .reset_n          (reset_n),
        .in_data          (in_data),
        .in_valid         (in_valid),
        .in_fragment_last (in_fragment_last),
        .in_final         (in_final),
        .in_packet_id     (in_packet_id),
        .out_ready        (out_ready),
        .out_data         (out_data),
        .out_valid        (out_valid),
        .out_last         (out_last),
        .out_packet_id    (out_packet_id),
        .drop             (drop)
    );

    task automatic stop_on_error();
        $display("Something failed");
        $fatal(1);
    endtask

    task automatic build_packet(input int h, input reassembly_pkg::packet_id_t id,
                                input int fragments, input int min_len, input int max_len);
        int length;
        length        = 0;
        packet_id[h]  = id;
        frag_count[h] = fragments;
        frag_index[h] = 0;
        sent_bytes[h] = 0;
        for (int k = 0; k < fragments; k++) begin
            frag_len[h][k] = $urandom_range(max_len, min_len);
            length = length + frag_len[h][k];
        end
        for (int i = 0; i < length; i++) begin
            packet_store[h][i] = 8'($urandom);
        end
        total_bytes = total_bytes + length;
    endtask

    task automatic pause(input int cycles);
        repeat (cycles) begin
            @(posedge clock);
            in_valid         <= 1'b0;
            in_fragment_last <= 1'b0;
        end
    endtask

    // Whole packet joins the scoreboard once its final byte is sent
    task automatic push_expected(input int h);
        for (int i = 0; i < sent_bytes[h]; i++) begin
            expected_data.push_back(packet_store[h][i]);
            expected_last.push_back(i == sent_bytes[h] - 1);
            expected_id.push_back(packet_id[h]);
        end
    endtask

    task automatic send_next_fragment(input int h, input logic accepted);
        int   offset;
        int   len;
        logic is_final;
        offset   = sent_bytes[h];
        len      = frag_len[h][frag_index[h]];
        is_final = (frag_index[h] == frag_count[h] - 1);
        for (int i = 0; i < len; i++) begin
            @(posedge clock);
            in_data          <= packet_store[h][offset + i];
            in_valid         <= 1'b1;
            in_fragment_last <= (i == len - 1);
            in_final         <= is_final;
            in_packet_id     <= packet_id[h];
        end
        sent_bytes[h] = offset + len;
        frag_index[h] = frag_index[h] + 1;
        if (is_final && accepted) begin
            push_expected(h);
        end
        pause($urandom_range(2, 0));
    endtask

    task automatic wait_drained();
        pause(1);
        while (expected_data.size() != 0) begin
            @(posedge clock);
        end
        // Slot back in idle shortly after its last byte
        repeat (3) @(posedge clock);
    endtask

    task automatic check_output();
        assert (expected_data.size() != 0) else begin
            $display("Output byte %h with id %h arrived while no packet was expected",
                     out_data, out_packet_id);
            stop_on_error();
        end
        assert (out_data == expected_data[0]) else begin
            $display("ERROR t=%0t out_data expected %h actual %h",
                     $time, expected_data[0], out_data);
            stop_on_error();
        end
        assert (out_last == expected_last[0]) else begin
            $display("ERROR t=%0t out_last expected %b actual %b",
                     $time, expected_last[0], out_last);
            stop_on_error();
        end
        assert (out_packet_id == expected_id[0]) else begin
            $display("ERROR t=%0t out_packet_id expected %h actual %h",
                     $time, expected_id[0], out_packet_id);
            stop_on_error();
        end
        void'(expected_data.pop_front());
        void'(expected_last.pop_front());
        void'(expected_id.pop_front());
    endtask

    //////////////////////////////////////////////////////////////////////
    // Output monitor, read enable and timeout
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        if (reset_n) begin
            if (drop) begin
                drop_count = drop_count + 1;
            end
            if (out_valid) begin
                check_output();
            end
        end
    end

    always @(posedge clock) begin
        if (ready_random) begin
            out_ready <= 1'($urandom_range(1, 0));
        end else begin
            out_ready <= ready_level;
        end
    end

    always @(posedge clock) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout after %0d cycles with %0d output bytes still expected",
                     cycle_limit, expected_data.size());
            stop_on_error();
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(49));
        in_data          = '0;
        in_valid         = 1'b0;
        in_fragment_last = 1'b0;
        in_final         = 1'b0;
        in_packet_id     = '0;
        out_ready        = 1'b0;
        ready_random     = 1'b0;
        ready_level      = 1'b1;
        total_bytes      = 0;
        drop_count       = 0;
        cycle_count      = 0;

        build_packet(0, 16'h1001, 1, 16, 64);
        build_packet(1, 16'h1002, 3, 8, 32);
        build_packet(2, 16'h2001, 3, 4, 24);
        build_packet(3, 16'h2002, 2, 4, 24);
        for (int h = 4; h < 8; h++) begin
            build_packet(h, reassembly_pkg::packet_id_t'(16'h3000 + h), 2, 4, 20);
        end
        build_packet(8, 16'h3100, 1, 8, 8);
        for (int h = 9; h < 12; h++) begin
            build_packet(h, reassembly_pkg::packet_id_t'(16'h4000 + h), 2, 6, 30);
        end
        cycle_limit = total_bytes * 4 + 2000;

        @(posedge reset_n);
        @(posedge clock);

        // Single final fragment
        send_next_fragment(0, 1'b1);
        wait_drained();

        // Three fragments, one packet
        repeat (3) send_next_fragment(1, 1'b1);
        wait_drained();

        // Interleaved ids where 2002 finishes first
        send_next_fragment(2, 1'b1);
        send_next_fragment(3, 1'b1);
        send_next_fragment(3, 1'b1);
        send_next_fragment(2, 1'b1);
        send_next_fragment(2, 1'b1);
        wait_drained();

        // Every slot held while output is stalled
        ready_level <= 1'b0;
        for (int s = 0; s < reassembly_pkg::num_slots; s++) begin
            send_next_fragment(4 + s, 1'b1);
        end
        assert (drop_count == 0) else begin
            $display("ERROR t=%0t drop_count expected %0d actual %0d", $time, 0, drop_count);
            stop_on_error();
        end
        send_next_fragment(8, 1'b0);
        pause(2);
        assert (drop_count == 1) else begin
            $display("ERROR t=%0t drop_count expected %0d actual %0d", $time, 1, drop_count);
            stop_on_error();
        end
        send_next_fragment(6, 1'b1);
        send_next_fragment(4, 1'b1);
        send_next_fragment(7, 1'b1);
        send_next_fragment(5, 1'b1);
        ready_random <= 1'b1;
        wait_drained();

        // Random back-pressure while fragments interleave
        send_next_fragment(9, 1'b1);
        send_next_fragment(10, 1'b1);
        send_next_fragment(11, 1'b1);
        send_next_fragment(9, 1'b1);
        send_next_fragment(11, 1'b1);
        send_next_fragment(10, 1'b1);
        wait_drained();

        if (drop_count == 1) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("ERROR t=%0t drop_count expected %0d actual %0d", $time, 1, drop_count);
            stop_on_error();
        end
    end

endmodule

// ==== list.f ====
common/reassembly_pkg.sv
common/fragment_stream_if.sv
logic/sync_fifo.sv
fragment_slot/fragment_slot.sv
fragment_slot/slot_dispatcher.sv
logic/drain_arbiter.sv
fragment_reassembly_top.sv
sim/clock_gen.sv
sim/reassembly_sva.sv
sim/tb_top.sv
